//--- list.f
logic/rv_pkg.sv
logic/wb_pkg.sv
logic/cpu_control.sv
logic/alu.sv
logic/decoder.sv
logic/register_file.sv
logic/wb_master.sv
logic/cpu.sv
sim/clock_gen.sv
sim/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module cpu_tb -o cpu_tb_sim

out=$(./obj_dir/cpu_tb_sim)
echo "$out"

echo "$out" | grep -q ">>> PASS"

//--- sim/cpu_tb.sv
module cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tests    = 5;
    localparam int max_cycles   = 400;
    localparam int reset_cycles = 10;
    localparam int clk_ns       = 4;
    // every test may run its full budget, plus reset and some slack
    localparam int watchdog_ns  = num_tests * max_cycles * clk_ns
                                + num_tests * (reset_cycles + 2) * clk_ns + 100;

    typedef struct packed {
        rv_pkg::word_t [11:0] prog;
        rv_pkg::word_t        data;
        rv_pkg::word_t        adr;
        rv_pkg::word_t        dat;
    } test_row_t;

    logic            clk;
    logic            reset;
    wb_pkg::wb_req_t bus_req;
    wb_pkg::wb_rsp_t bus_rsp;

    test_row_t     tests [num_tests];
    string         names [num_tests];
    rv_pkg::word_t mem [64];

    // memory model state
    logic          pending;
    int            delay;
    logic          store_seen;
    rv_pkg::word_t store_adr;
    rv_pkg::word_t store_dat;

    int passed;
    int failed;
    int errors;

    clock_gen #(.period(4ns)) u_clk (.clk(clk));

    cpu dut (
        .clk     (clk),
        .reset   (reset),
        .bus_rsp (bus_rsp),
        .bus_req (bus_req)
    );

    // hand-assembled RV32I programs, one row per test
    task automatic fill_tests();
        for (int i = 0; i < num_tests; i++) begin
            tests[i] = '0;
        end

        names[0] = "register arithmetic";
        tests[0].prog[0] = 32'h06400093;  // addi x1, x0, 100
        tests[0].prog[1] = 32'hFF900113;  // addi x2, x0, -7
        tests[0].prog[2] = 32'h002081B3;  // add  x3, x1, x2
        tests[0].prog[3] = 32'h40208233;  // sub  x4, x1, x2
        tests[0].prog[4] = 32'h0041C2B3;  // xor  x5, x3, x4
        tests[0].prog[5] = 32'h0012E333;  // or   x6, x5, x1
        tests[0].prog[6] = 32'h002373B3;  // and  x7, x6, x2
        tests[0].prog[7] = 32'h08702223;  // sw   x7, 0x84(x0)
        tests[0].prog[8] = 32'h0000006F;  // jal  x0, 0
        tests[0].adr = 32'h84;
        // 93 ^ 107 = 0x36, | 100 = 0x76, & -7 = 0x70
        tests[0].dat = 32'h70;

        names[1] = "immediate shifts and compares";
        tests[1].prog[0]  = 32'hFF000093;  // addi  x1, x0, -16
        tests[1].prog[1]  = 32'h00409113;  // slli  x2, x1, 4
        tests[1].prog[2]  = 32'h40815193;  // srai  x3, x2, 8
        tests[1].prog[3]  = 32'h0050A213;  // slti  x4, x1, 5
        tests[1].prog[4]  = 32'h0050B293;  // sltiu x5, x1, 5
        tests[1].prog[5]  = 32'hFFF03313;  // sltiu x6, x0, -1
        tests[1].prog[6]  = 32'h00620433;  // add   x8, x4, x6
        tests[1].prog[7]  = 32'h00540433;  // add   x8, x8, x5
        tests[1].prog[8]  = 32'h0081C4B3;  // xor   x9, x3, x8
        tests[1].prog[9]  = 32'h08902223;  // sw    x9, 0x84(x0)
        tests[1].prog[10] = 32'h0000006F;  // jal   x0, 0
        tests[1].adr = 32'h84;
        // -256 >>> 8 = -1, compares give 1 + 1 + 0
        tests[1].dat = 32'hFFFFFFFD;

        names[2] = "load and store";
        tests[2].prog[0] = 32'h08002083;  // lw   x1, 0x80(x0)
        tests[2].prog[1] = 32'h12308113;  // addi x2, x1, 0x123
        tests[2].prog[2] = 32'h08202423;  // sw   x2, 0x88(x0)
        tests[2].prog[3] = 32'h0000006F;  // jal  x0, 0
        tests[2].data = 32'h12345678;
        tests[2].adr  = 32'h88;
        tests[2].dat  = 32'h1234579B;

        names[3] = "branches";
        tests[3].prog[0]  = 32'hFFD00093;  // addi x1, x0, -3
        tests[3].prog[1]  = 32'h00008863;  // beq  x1, x0, +16  not taken
        tests[3].prog[2]  = 32'h00104863;  // blt  x0, x1, +16  not taken
        tests[3].prog[3]  = 32'h00107863;  // bgeu x0, x1, +16  not taken
        tests[3].prog[4]  = 32'h00100513;  // addi x10, x0, 1
        tests[3].prog[5]  = 32'h00000463;  // beq  x0, x0, +8   taken
        tests[3].prog[6]  = 32'h00250513;  // addi x10, x10, 2
        tests[3].prog[7]  = 32'h0000C463;  // blt  x1, x0, +8   taken
        tests[3].prog[8]  = 32'h00450513;  // addi x10, x10, 4
        tests[3].prog[9]  = 32'h0000F463;  // bgeu x1, x0, +8   taken
        tests[3].prog[10] = 32'h00850513;  // addi x10, x10, 8
        tests[3].prog[11] = 32'h08A02623;  // sw   x10, 0x8c(x0)
        tests[3].adr = 32'h8C;
        // only the fall-through marker ran, every skip bit stays clear
        tests[3].dat = 32'h1;

        names[4] = "jumps and upper immediates";
        tests[4].prog[0]  = 32'h123450B7;  // lui   x1, 0x12345
        tests[4].prog[1]  = 32'h00001117;  // auipc x2, 0x1
        tests[4].prog[2]  = 32'h00C001EF;  // jal   x3, +12
        tests[4].prog[3]  = 32'h00000093;  // addi  x1, x0, 0  skipped
        tests[4].prog[4]  = 32'h00000093;  // addi  x1, x0, 0  skipped
        tests[4].prog[5]  = 32'h01018267;  // jalr  x4, 16(x3)
        tests[4].prog[6]  = 32'h00000093;  // addi  x1, x0, 0  skipped
        tests[4].prog[7]  = 32'h004182B3;  // add   x5, x3, x4
        tests[4].prog[8]  = 32'h0020C333;  // xor   x6, x1, x2
        tests[4].prog[9]  = 32'h005303B3;  // add   x7, x6, x5
        tests[4].prog[10] = 32'h08702823;  // sw    x7, 0x90(x0)
        tests[4].prog[11] = 32'h0000006F;  // jal   x0, 0
        tests[4].adr = 32'h90;
        // links 0x0c and 0x18, 0x12345000 ^ 0x1004
        tests[4].dat = 32'h12344004 + 32'h0C + 32'h18;
    endtask

    task automatic load_memory(input int t);
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < 12; i++) begin
            mem[i] = tests[t].prog[i];
        end
        mem[32] = tests[t].data;
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_for_store(output logic arrived);
        int cycles;
        cycles = 0;
        while (!store_seen && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        arrived = store_seen;
    endtask

    task automatic run_test(input int t);
        logic arrived;
        @(negedge clk);
        reset      = 1'b1;
        store_seen = 1'b0;
        load_memory(t);
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        errors = 0;
        wait_for_store(arrived);
        if (!arrived) begin
            $display("test %0d %s: no store arrived within %0d cycles",
                     t, names[t], max_cycles);
            failed++;
        end else begin
            check_word("bus_req.adr", store_adr, tests[t].adr);
            check_word("bus_req.dat", store_dat, tests[t].dat);
            if (errors == 0) begin
                $display("test %0d %s: ok", t, names[t]);
                passed++;
            end else begin
                $display("test %0d %s: wrong store", t, names[t]);
                failed++;
            end
        end
    endtask

    // word memory, acked after 0 to 3 cycles
    initial begin
        void'($urandom(32'h80fe_af7b));
        forever begin
            @(negedge clk);
            bus_rsp.ack = 1'b0;
            if (reset) begin
                pending = 1'b0;
            end else if (bus_req.cyc && bus_req.stb) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = $urandom_range(3, 0);
                end
                if (delay == 0) begin
                    pending     = 1'b0;
                    bus_rsp.ack = 1'b1;
                    if (bus_req.we) begin
                        mem[bus_req.adr[7:2]] = bus_req.dat;
                        if (!store_seen) begin
                            store_seen = 1'b1;
                            store_adr  = bus_req.adr;
                            store_dat  = bus_req.dat;
                        end
                    end else begin
                        bus_rsp.dat = mem[bus_req.adr[7:2]];
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        #(watchdog_ns * 1ns);
        $display("watchdog expired before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        bus_rsp    = '0;
        pending    = 1'b0;
        delay      = 0;
        store_seen = 1'b0;
        store_adr  = '0;
        store_dat  = '0;
        passed     = 0;
        failed     = 0;
        fill_tests();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("passed %0d failed %0d", passed, failed);
        if (failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim/clock_gen.sv
module clock_gen #(
    parameter realtime period = 4ns
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

//--- logic/cpu.sv
module cpu (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_rsp_t bus_rsp,
    output wb_pkg::wb_req_t bus_req
);

    rv_pkg::ctrl_t        ctrl;
    rv_pkg::word_t        pc;
    rv_pkg::word_t        alu_result;
    logic                 lt;
    logic                 ltu;
    logic                 eq;
    rv_pkg::reg_idx_t     rs1;
    rv_pkg::reg_idx_t     rs2;
    rv_pkg::reg_idx_t     rd;
    rv_pkg::word_t        imm;
    rv_pkg::opcode_t      opcode;
    logic [2:0]           funct3;
    logic                 funct7_bit;
    rv_pkg::branch_mask_t branch_mask;
    rv_pkg::word_t        val1;
    rv_pkg::word_t        val2;
    rv_pkg::word_t        read_data;
    logic                 busy;

    cpu_control u_control (
        .clk         (clk),
        .reset       (reset),
        .busy        (busy),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7_bit  (funct7_bit),
        .branch_mask (branch_mask),
        .lt          (lt),
        .ltu         (ltu),
        .eq          (eq),
        .alu_result  (alu_result),
        .ctrl        (ctrl),
        .pc          (pc)
    );

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .reg_val1 (val1),
        .reg_val2 (val2),
        .imm      (imm),
        .pc       (pc),
        .result   (alu_result),
        .lt       (lt),
        .ltu      (ltu),
        .eq       (eq)
    );

    // instruction word comes from the bus master's read register
    decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .instr       (read_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7_bit  (funct7_bit),
        .branch_mask (branch_mask)
    );

    register_file u_regs (
        .clk        (clk),
        .ctrl       (ctrl),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .alu_result (alu_result),
        .bus_data   (read_data),
        .imm        (imm),
        .val1       (val1),
        .val2       (val2)
    );

    wb_master u_bus (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_result (alu_result),
        .store_data (val2),
        .bus_rsp    (bus_rsp),
        .bus_req    (bus_req),
        .read_data  (read_data),
        .busy       (busy)
    );

endmodule

//--- logic/wb_master.sv
module wb_master (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::ctrl_t   ctrl,
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   alu_result,
    input  rv_pkg::word_t   store_data,
    input  wb_pkg::wb_rsp_t bus_rsp,
    output wb_pkg::wb_req_t bus_req,
    output rv_pkg::word_t   read_data,
    output logic            busy
);

    wb_pkg::wb_req_t req_q;
    logic            start;
    logic            done;

    // bus_en is repeated while stalled, only an idle bus starts a cycle
    assign start = ctrl.bus_en && !req_q.cyc;
    assign done  = req_q.cyc && bus_rsp.ack;

    assign bus_req = req_q;
    assign busy    = req_q.cyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            req_q.we  <= 1'b0;
        end else if (start) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.we  <= ctrl.bus_write;
        end else if (done) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            req_q.we  <= 1'b0;
        end
    end

    // address and data stay put for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            req_q.adr <= ctrl.addr_from_pc ? pc : alu_result;
            req_q.dat <= store_data;
        end
        if (done && !req_q.we) begin
            read_data <= bus_rsp.dat;
        end
    end

endmodule

//--- logic/register_file.sv
module register_file (
    input  logic             clk,
    input  rv_pkg::ctrl_t    ctrl,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    alu_result,
    input  rv_pkg::word_t    bus_data,
    input  rv_pkg::word_t    imm,
    output rv_pkg::word_t    val1,
    output rv_pkg::word_t    val2
);

    rv_pkg::word_t regs [32];
    rv_pkg::word_t wr_data;

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::wbsel_bus: wr_data = bus_data;
            rv_pkg::wbsel_imm: wr_data = imm;
            default:           wr_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.reg_write && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    // x0 is never written, so mask it on read
    always_ff @(posedge clk) begin
        if (ctrl.reg_read) begin
            val1 <= (rs1 == '0) ? '0 : regs[rs1];
            val2 <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

//--- logic/decoder.sv
module decoder (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pkg::ctrl_t        ctrl,
    input  rv_pkg::word_t        instr,
    output rv_pkg::reg_idx_t     rs1,
    output rv_pkg::reg_idx_t     rs2,
    output rv_pkg::reg_idx_t     rd,
    output rv_pkg::word_t        imm,
    output rv_pkg::opcode_t      opcode,
    output logic [2:0]           funct3,
    output logic                 funct7_bit,
    output rv_pkg::branch_mask_t branch_mask
);

    rv_pkg::opcode_t      opc;
    rv_pkg::word_t        imm_d;
    rv_pkg::branch_mask_t mask_d;

    assign opc = rv_pkg::opcode_t'(instr[6:2]);

    // read indices straight from the held instruction so the
    // register read can share the decode cycle
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        case (opc)
            rv_pkg::opc_store:
                imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::opc_branch:
                imm_d = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::opc_lui, rv_pkg::opc_auipc:
                imm_d = {instr[31:12], 12'b0};
            rv_pkg::opc_jal:
                imm_d = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm_d = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        case (instr[14:12])
            rv_pkg::f3_beq:  mask_d = 6'b000001;
            rv_pkg::f3_bne:  mask_d = 6'b000010;
            rv_pkg::f3_blt:  mask_d = 6'b000100;
            rv_pkg::f3_bge:  mask_d = 6'b001000;
            rv_pkg::f3_bltu: mask_d = 6'b010000;
            rv_pkg::f3_bgeu: mask_d = 6'b100000;
            default:         mask_d = 6'b000000;
        endcase
        if (opc != rv_pkg::opc_branch) begin
            mask_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opcode      <= rv_pkg::opc_misc_mem;
            branch_mask <= '0;
        end else if (ctrl.dec_en) begin
            opcode      <= opc;
            branch_mask <= mask_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.dec_en) begin
            rd         <= instr[11:7];
            imm        <= imm_d;
            funct3     <= instr[14:12];
            funct7_bit <= instr[30];
        end
    end

endmodule

//--- logic/alu.sv
module alu (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t reg_val1,
    input  rv_pkg::word_t reg_val2,
    input  rv_pkg::word_t imm,
    input  rv_pkg::word_t pc,
    output rv_pkg::word_t result,
    output logic          lt,
    output logic          ltu,
    output logic          eq
);

    rv_pkg::word_t op1;
    rv_pkg::word_t op2;
    rv_pkg::word_t res;

    assign op1 = (ctrl.src1_sel == rv_pkg::src1_pc) ? pc : reg_val1;

    always_comb begin
        case (ctrl.src2_sel)
            rv_pkg::src2_imm: op2 = imm;
            rv_pkg::src2_len: op2 = rv_pkg::instr_len;
            default:          op2 = reg_val2;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_sub:  res = op1 - op2;
            rv_pkg::alu_sll:  res = op1 << op2[4:0];
            rv_pkg::alu_slt:  res = {31'b0, $signed(op1) < $signed(op2)};
            rv_pkg::alu_sltu: res = {31'b0, op1 < op2};
            rv_pkg::alu_xor:  res = op1 ^ op2;
            rv_pkg::alu_srl:  res = op1 >> op2[4:0];
            rv_pkg::alu_sra:  res = $signed(op1) >>> op2[4:0];
            rv_pkg::alu_or:   res = op1 | op2;
            rv_pkg::alu_and:  res = op1 & op2;
            default:          res = op1 + op2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.alu_en) begin
            result <= res;
        end
    end

    // compare flags feed the branch decision
    always_ff @(posedge clk) begin
        if (reset) begin
            lt  <= 1'b0;
            ltu <= 1'b0;
            eq  <= 1'b0;
        end else if (ctrl.alu_en) begin
            lt  <= $signed(op1) < $signed(op2);
            ltu <= op1 < op2;
            eq  <= op1 == op2;
        end
    end

endmodule

//--- logic/cpu_control.sv
module cpu_control (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 busy,
    input  rv_pkg::opcode_t      opcode,
    input  logic [2:0]           funct3,
    input  logic                 funct7_bit,
    input  rv_pkg::branch_mask_t branch_mask,
    input  logic                 lt,
    input  logic                 ltu,
    input  logic                 eq,
    input  rv_pkg::word_t        alu_result,
    output rv_pkg::ctrl_t        ctrl,
    output rv_pkg::word_t        pc
);

    typedef enum logic [2:0] {
        st_reset, st_fetch, st_decode, st_exec, st_load2, st_store2, st_branch2
    } state_t;

    state_t        prev_state;
    state_t        next_state;
    state_t        cur_state;
    rv_pkg::word_t pc_q;
    rv_pkg::word_t pc_next;
    rv_pkg::word_t fetch_pc;
    logic          nextpc_from_alu;
    logic          wb_from_alu;
    logic          wb_from_bus;
    logic          branch_taken;

    // register ops may subtract, immediate ops never do
    function automatic rv_pkg::alu_op_t alu_op_for(logic [2:0] f3, logic alt, logic is_reg);
        case (f3)
            rv_pkg::f3_add_sub: return (alt && is_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:     return rv_pkg::alu_sll;
            rv_pkg::f3_slt:     return rv_pkg::alu_slt;
            rv_pkg::f3_sltu:    return rv_pkg::alu_sltu;
            rv_pkg::f3_xor:     return rv_pkg::alu_xor;
            rv_pkg::f3_srl_sra: return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:      return rv_pkg::alu_or;
            default:            return rv_pkg::alu_and;
        endcase
    endfunction

    // a stalled bus keeps the state that started the access
    assign cur_state = busy ? prev_state : next_state;

    assign branch_taken = |(branch_mask & {~ltu, ltu, ~lt, lt, ~eq, eq});
    assign fetch_pc     = nextpc_from_alu ? {alu_result[31:1], 1'b0} : pc_next;

    // the fetch address is needed on the same edge that loads pc_q
    assign pc = (cur_state == st_fetch) ? fetch_pc : pc_q;

    always_comb begin
        ctrl = '0;
        case (cur_state)
            st_fetch: begin
                // retire the previous instruction's result
                ctrl.reg_write    = wb_from_alu | wb_from_bus;
                ctrl.wb_sel       = wb_from_alu ? rv_pkg::wbsel_alu : rv_pkg::wbsel_bus;
                ctrl.bus_en       = 1'b1;
                ctrl.addr_from_pc = 1'b1;
            end
            st_decode: begin
                ctrl.dec_en   = 1'b1;
                ctrl.reg_read = 1'b1;
                // idle alu works out the fall-through pc
                ctrl.alu_en   = 1'b1;
                ctrl.src1_sel = rv_pkg::src1_pc;
                ctrl.src2_sel = rv_pkg::src2_len;
            end
            st_exec: begin
                case (opcode)
                    rv_pkg::opc_op: begin
                        ctrl.alu_en = 1'b1;
                        ctrl.alu_op = alu_op_for(funct3, funct7_bit, 1'b1);
                    end
                    rv_pkg::opc_op_imm: begin
                        ctrl.alu_en   = 1'b1;
                        ctrl.alu_op   = alu_op_for(funct3, funct7_bit, 1'b0);
                        ctrl.src2_sel = rv_pkg::src2_imm;
                    end
                    rv_pkg::opc_load, rv_pkg::opc_store: begin
                        ctrl.alu_en   = 1'b1;
                        ctrl.src2_sel = rv_pkg::src2_imm;
                    end
                    rv_pkg::opc_jal, rv_pkg::opc_jalr: begin
                        // alu still holds pc + 4 for the link
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_en    = 1'b1;
                        ctrl.src1_sel  = (opcode == rv_pkg::opc_jal) ? rv_pkg::src1_pc
                                                                     : rv_pkg::src1_reg;
                        ctrl.src2_sel  = rv_pkg::src2_imm;
                    end
                    rv_pkg::opc_branch: begin
                        // compare flags only
                        ctrl.alu_en = 1'b1;
                    end
                    rv_pkg::opc_auipc: begin
                        ctrl.alu_en   = 1'b1;
                        ctrl.src1_sel = rv_pkg::src1_pc;
                        ctrl.src2_sel = rv_pkg::src2_imm;
                    end
                    rv_pkg::opc_lui: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.wb_sel    = rv_pkg::wbsel_imm;
                    end
                    default: ;
                endcase
            end
            st_load2: begin
                ctrl.bus_en = 1'b1;
            end
            st_store2: begin
                ctrl.bus_en    = 1'b1;
                ctrl.bus_write = 1'b1;
            end
            st_branch2: begin
                // branch target, used only if taken
                ctrl.alu_en   = 1'b1;
                ctrl.src1_sel = rv_pkg::src1_pc;
                ctrl.src2_sel = rv_pkg::src2_imm;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_state      <= st_reset;
            next_state      <= st_reset;
            pc_q            <= rv_pkg::reset_vector;
            pc_next         <= rv_pkg::reset_vector;
            nextpc_from_alu <= 1'b0;
            wb_from_alu     <= 1'b0;
            wb_from_bus     <= 1'b0;
        end else begin
            prev_state <= cur_state;
            next_state <= st_fetch;
            case (cur_state)
                st_reset: begin
                    pc_next <= rv_pkg::reset_vector;
                end
                st_fetch: begin
                    pc_q        <= fetch_pc;
                    wb_from_alu <= 1'b0;
                    wb_from_bus <= 1'b0;
                    next_state  <= st_decode;
                end
                st_decode: begin
                    nextpc_from_alu <= 1'b0;
                    next_state      <= st_exec;
                end
                st_exec: begin
                    // alu result here is pc + 4 from decode
                    pc_next <= alu_result;
                    case (opcode)
                        rv_pkg::opc_op, rv_pkg::opc_op_imm, rv_pkg::opc_auipc:
                            wb_from_alu <= 1'b1;
                        rv_pkg::opc_load:   next_state <= st_load2;
                        rv_pkg::opc_store:  next_state <= st_store2;
                        rv_pkg::opc_branch: next_state <= st_branch2;
                        rv_pkg::opc_jal, rv_pkg::opc_jalr:
                            nextpc_from_alu <= 1'b1;
                        default: ;
                    endcase
                end
                st_load2: begin
                    wb_from_bus <= 1'b1;
                end
                st_branch2: begin
                    nextpc_from_alu <= branch_taken;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- logic/wb_pkg.sv
package wb_pkg;

    // master to slave
    typedef struct packed {
        logic          cyc;
        logic          stb;
        logic          we;
        rv_pkg::word_t adr;
        rv_pkg::word_t dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic          ack;
        rv_pkg::word_t dat;
    } wb_rsp_t;

endpackage

//--- logic/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // one-hot from bit 0: eq, ne, lt, ge, ltu, geu
    typedef logic [5:0]  branch_mask_t;

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        opc_load     = 5'b00000,
        opc_misc_mem = 5'b00011,
        opc_op_imm   = 5'b00100,
        opc_auipc    = 5'b00101,
        opc_store    = 5'b01000,
        opc_op       = 5'b01100,
        opc_lui      = 5'b01101,
        opc_branch   = 5'b11000,
        opc_jalr     = 5'b11001,
        opc_jal      = 5'b11011
    } opcode_t;

    // arithmetic funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic       {src1_reg, src1_pc} src1_sel_t;
    typedef enum logic [1:0] {src2_reg, src2_imm, src2_len} src2_sel_t;
    typedef enum logic [1:0] {wbsel_alu, wbsel_bus, wbsel_imm} wb_sel_t;

    // all-zero value is idle: add, reg operands, alu writeback
    typedef struct packed {
        logic      alu_en;
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        logic      reg_read;
        logic      reg_write;
        wb_sel_t   wb_sel;
        logic      dec_en;
        logic      bus_en;
        logic      bus_write;
        logic      addr_from_pc;
    } ctrl_t;

    localparam word_t reset_vector = 32'h0000_0000;
    localparam word_t instr_len    = 32'd4;

endpackage
